// ==== div_unit.f ====
+incdir+include
verilog/div_pkg.sv
verilog/cla_block.sv
verilog/cla_64.sv
verilog/div_operand_prep.sv
verilog/div_iter_ctrl.sv
verilog/div_datapath.sv
verilog/div_result_fix.sv
verilog/div_unit.sv
tb/div_unit_tb.sv

// ==== include/div_defs.svh ====
`ifndef DIV_DEFS_SVH
`define DIV_DEFS_SVH

// Operand, quotient, remainder and result width
`define DIV_WIDTH 64

// One quotient bit is produced per iteration
`define DIV_STEPS 64
`define DIV_CNT_W 6

`endif

// ==== tb/div_unit_tb.sv ====
`timescale 1ns/1ps

`include "div_defs.svh"

module div_unit_tb
  import div_pkg::*;
();

  localparam TEST_FILE = "tb/div_unit_tests.txt";
  localparam int LATENCY = `DIV_STEPS + 2;
  localparam int BUSY_CYCLE = 20;

  logic       clk;
  logic       rst_n;
  div_word_t  dividend;
  div_word_t  divisor;
  logic [1:0] div_type;
  logic       div_valid;
  logic       flush;
  logic       div_ready;
  logic       out_valid;
  div_word_t  result;

  logic [1:0]  t_type[$];
  div_word_t   t_dividend[$];
  div_word_t   t_divisor[$];
  div_word_t   t_expected[$];
  int          t_flush[$];
  int          errors;
  int          cycle_count;
  int          cycle_limit;
  logic [31:0] rng_state;
  div_word_t   last_result;
  logic        have_last;

  div_unit div_unit_i (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_limit != 0 && cycle_count > cycle_limit) begin
      $display("Timeout: the run went past %0d cycles without finishing", cycle_limit);
      $display("Done: errors found");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] %0t %s: got %h, expected %h", $time, what, actual, expected);
    end
  endtask

  // Inputs change and outputs are sampled 2 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic read_tests();
    int               fd;
    int               op_code;
    int               fl;
    div_word_t        a;
    div_word_t        b;
    div_word_t        q;
    logic [8*160-1:0] line;
    fd = $fopen(TEST_FILE, "r");
    if (fd == 0) begin
      $display("Could not open the test file %s", TEST_FILE);
    end else begin
      // Comment lines do not match all five fields and are skipped
      while ($fgets(line, fd) != 0) begin
        if ($sscanf(line, "%d %h %h %h %d", op_code, a, b, q, fl) == 5) begin
          t_type.push_back(op_code[1:0]);
          t_dividend.push_back(a);
          t_divisor.push_back(b);
          t_expected.push_back(q);
          t_flush.push_back(fl);
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic run_operation(input int idx);
    int   j;
    logic flushed;
    check_value(div_ready, 1'b1, $sformatf("test %0d div_ready at request", idx));
    if (have_last)
      check_value(result, last_result, $sformatf("test %0d result hold", idx));
    dividend  = t_dividend[idx];
    divisor   = t_divisor[idx];
    div_type  = t_type[idx];
    div_valid = 1'b1;
    next_cycle();
    j       = 0;
    flushed = 1'b0;
    // Busy until out_valid, or ready for the rest of the window once flushed
    while (!out_valid && j < LATENCY + 4) begin
      check_value(div_ready, flushed, $sformatf("test %0d div_ready at cycle %0d", idx, j));
      flush     = (j + 1 == t_flush[idx]);
      div_valid = flush || (j == BUSY_CYCLE && !flushed);
      if (div_valid) begin
        rng_state = xorshift32(rng_state);
        dividend  = {rng_state, ~rng_state};
        divisor   = {~rng_state, rng_state};
        div_type  = rng_state[1:0];
      end
      next_cycle();
      j++;
      flushed = flushed || flush;
    end
    flush     = 1'b0;
    div_valid = 1'b0;
    if (flushed) begin
      check_value(j, LATENCY + 4, $sformatf("test %0d cycles without out_valid", idx));
      have_last = 1'b0;
    end else begin
      check_value(j, LATENCY, $sformatf("test %0d latency", idx));
      check_value(result, t_expected[idx], $sformatf("test %0d result", idx));
      check_value(div_ready, 1'b1, $sformatf("test %0d div_ready at out_valid", idx));
      last_result = t_expected[idx];
      have_last   = 1'b1;
      next_cycle();
      check_value(out_valid, 1'b0, $sformatf("test %0d out_valid pulse width", idx));
      check_value(result, last_result, $sformatf("test %0d result after pulse", idx));
    end
  endtask

  initial begin
    rst_n       = 1'b0;
    dividend    = '0;
    divisor     = '0;
    div_type    = 2'b00;
    div_valid   = 1'b0;
    flush       = 1'b0;
    errors      = 0;
    cycle_count = 0;
    cycle_limit = 0;
    rng_state   = 32'hb910b276;
    last_result = '0;
    have_last   = 1'b0;
    read_tests();
    if (t_type.size() == 0) begin
      $display("No tests were read, nothing was checked");
      errors++;
    end else begin
      cycle_limit = t_type.size() * 80 + 200;
      repeat (8) @(posedge clk);
      #2;
      rst_n = 1'b1;
      check_value(div_ready, 1'b1, "div_ready after reset");
      check_value(out_valid, 1'b0, "out_valid after reset");
      check_value(result, '0, "result after reset");
      have_last = 1'b1;
      for (int i = 0; i < t_type.size(); i++) begin
        rng_state = xorshift32(rng_state);
        repeat (rng_state[1:0]) begin
          check_value(out_valid, 1'b0, "out_valid between operations");
          if (have_last)
            check_value(result, last_result, "result hold between operations");
          next_cycle();
        end
        run_operation(i);
      end
    end
    $display("Checks finished with %0d errors", errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== tb/div_unit_tests.txt ====
# div_type dividend divisor expected flush_cycle (values in hex, type and flush in decimal)
# div_type bit 0 selects signed, bit 1 selects remainder; flush_cycle 0 means no flush
0 0000000000000064 0000000000000007 000000000000000e 0
2 0000000000000064 0000000000000007 0000000000000002 0
0 ffffffffffffffff 0000000000000010 0fffffffffffffff 0
2 ffffffffffffffff 0000000000000010 000000000000000f 0
0 0000000000000005 8000000000000000 0000000000000000 0
2 0000000000000005 8000000000000000 0000000000000005 0
0 deadbeefcafebabe 0000000000000001 deadbeefcafebabe 0
2 deadbeefcafebabe 0000000000000001 0000000000000000 0
0 123456789abcdef0 0000000000000100 00123456789abcde 1
2 123456789abcdef0 0000000000000100 00000000000000f0 0
0 8000000000000000 0000000000000003 2aaaaaaaaaaaaaaa 0
2 8000000000000000 0000000000000003 0000000000000002 0
0 ffffffffffffffff 00000000ffffffff 0000000100000001 0
1 8000000000000000 0000000000000002 c000000000000000 30
1 0000000000000064 0000000000000007 000000000000000e 0
1 0000000000000064 fffffffffffffff9 fffffffffffffff2 0
3 0000000000000064 fffffffffffffff9 0000000000000002 0
1 ffffffffffffff9c 0000000000000007 fffffffffffffff2 0
3 ffffffffffffff9c 0000000000000007 fffffffffffffffe 0
1 ffffffffffffff9c fffffffffffffff9 000000000000000e 0
3 ffffffffffffff9c fffffffffffffff9 fffffffffffffffe 0
2 0000000000000064 0000000000000007 0000000000000002 65
1 8000000000000000 ffffffffffffffff 8000000000000000 0
3 8000000000000000 ffffffffffffffff 0000000000000000 0
1 ffffffffffffffff 7fffffffffffffff 0000000000000000 0
3 ffffffffffffffff 7fffffffffffffff ffffffffffffffff 0

// ==== verilog/cla_64.sv ====
`timescale 1ns/1ps

`include "div_defs.svh"

module cla_64
  import div_pkg::*;
(
  input  div_word_t a,
  input  div_word_t b,
  input  logic      cin,
  output div_word_t sum,
  output logic      cout
);

  localparam int NUM_GRP = `DIV_WIDTH / 4;

  logic [NUM_GRP-1:0] pg;
  logic [NUM_GRP-1:0] gg;
  logic [NUM_GRP-1:0] gc;

  // Propagate, generate and carry-in of each set of four groups
  logic [3:0] sp;
  logic [3:0] sg;
  logic [3:0] sc;

  genvar i;
  genvar j;

  generate
    for (i = 0; i < NUM_GRP; i++) begin : g_grp
      cla_block cla_block_i (
        .a   (a[4*i +: 4]),
        .b   (b[4*i +: 4]),
        .cin (gc[i]),
        .sum (sum[4*i +: 4]),
        .pg  (pg[i]),
        .gg  (gg[i])
      );
    end

    for (j = 0; j < 4; j++) begin : g_set
      logic [3:0] p;
      logic [3:0] g;

      assign p = pg[4*j +: 4];
      assign g = gg[4*j +: 4];

      // Group carries inside the set are formed from the set carry-in
      assign gc[4*j]   = sc[j];
      assign gc[4*j+1] = g[0] | (p[0] & sc[j]);
      assign gc[4*j+2] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & sc[j]);
      assign gc[4*j+3] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0]) |
                         (p[2] & p[1] & p[0] & sc[j]);

      assign sp[j] = &p;
      assign sg[j] = g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1]) |
                     (p[3] & p[2] & p[1] & g[0]);
    end
  endgenerate

  // Set carries are fully expanded from cin
  assign sc[0] = cin;
  assign sc[1] = sg[0] | (sp[0] & cin);
  assign sc[2] = sg[1] | (sp[1] & sg[0]) | (sp[1] & sp[0] & cin);
  assign sc[3] = sg[2] | (sp[2] & sg[1]) | (sp[2] & sp[1] & sg[0]) |
                 (sp[2] & sp[1] & sp[0] & cin);

  assign cout = sg[3] | (sp[3] & sg[2]) | (sp[3] & sp[2] & sg[1]) |
                (sp[3] & sp[2] & sp[1] & sg[0]) |
                (sp[3] & sp[2] & sp[1] & sp[0] & cin);

endmodule

// ==== verilog/cla_block.sv ====
`timescale 1ns/1ps

module cla_block (
  input  logic [3:0] a,
  input  logic [3:0] b,
  input  logic       cin,
  output logic [3:0] sum,
  output logic       pg,
  output logic       gg
);

  logic [3:0] p;
  logic [3:0] g;
  logic [3:0] c;

  assign p = a ^ b;
  assign g = a & b;

  // All bit carries come straight from cin without ripple inside the group
  assign c[0] = cin;
  assign c[1] = g[0] | (p[0] & cin);
  assign c[2] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & cin);
  assign c[3] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0]) |
                (p[2] & p[1] & p[0] & cin);

  assign sum = p ^ c;

  assign pg = &p;
  assign gg = g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1]) |
              (p[3] & p[2] & p[1] & g[0]);

endmodule

// ==== verilog/div_datapath.sv ====
`timescale 1ns/1ps

`include "div_defs.svh"

module div_datapath
  import div_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      load,
  input  logic      step,
  input  logic      correct,
  input  div_word_t dividend_mag,
  input  div_word_t divisor_mag,
  output div_word_t quotient,
  output div_word_t remainder
);

  div_rem_t  rem;
  div_word_t quo;
  div_word_t dsr;

  div_word_t add_a;
  div_word_t add_b;
  div_word_t add_sum;
  logic      add_cin;
  logic      add_cout;
  logic      sub;
  logic      top_in;
  logic      new_sign;

  // A non-negative remainder subtracts the divisor, a negative one adds it
  assign sub = !correct && !rem[`DIV_WIDTH];

  // During a step the remainder shifts left and takes in the next dividend bit
  assign add_a  = correct ? rem[`DIV_WIDTH-1:0] :
                  {rem[`DIV_WIDTH-2:0], quo[`DIV_WIDTH-1]};
  assign top_in = correct ? rem[`DIV_WIDTH] : rem[`DIV_WIDTH-1];

  assign add_b   = sub ? ~dsr : dsr;
  assign add_cin = sub;

  // Bit 64 of the sum sees an extended divisor bit that is 1 only when subtracting
  assign new_sign = top_in ^ sub ^ add_cout;

  cla_64 cla_64_i (
    .a    (add_a),
    .b    (add_b),
    .cin  (add_cin),
    .sum  (add_sum),
    .cout (add_cout)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rem <= '0;
      quo <= '0;
    end else if (load) begin
      rem <= '0;
      quo <= dividend_mag;
    end else if (step) begin
      rem <= {new_sign, add_sum};
      quo <= {quo[`DIV_WIDTH-2:0], ~new_sign};
    end else if (correct && rem[`DIV_WIDTH]) begin
      // Adding the divisor back restores the true remainder
      rem <= {new_sign, add_sum};
    end
  end

  always_ff @(posedge clk) begin
    if (load)
      dsr <= divisor_mag;
  end

  assign quotient  = quo;
  assign remainder = rem[`DIV_WIDTH-1:0];

endmodule

// ==== verilog/div_iter_ctrl.sv ====
`timescale 1ns/1ps

`include "div_defs.svh"

module div_iter_ctrl
  import div_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic div_valid,
  input  logic flush,
  output logic accept,
  output logic load,
  output logic step,
  output logic correct,
  output logic div_ready,
  output logic out_valid
);

  div_state_t            state;
  logic [`DIV_CNT_W-1:0] cnt;
  logic                  load_r;
  logic                  out_valid_r;

  assign div_ready = (state == IDLE) || (state == DONE);
  assign accept    = div_valid && div_ready && !flush;

  // The first RUN cycle only loads the datapath and the steps follow it
  assign load      = load_r;
  assign step      = (state == RUN) && !load_r;
  assign correct   = (state == CORRECT);
  assign out_valid = out_valid_r;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= IDLE;
      cnt         <= '0;
      load_r      <= 1'b0;
      out_valid_r <= 1'b0;
    end else if (flush) begin
      state       <= IDLE;
      cnt         <= '0;
      load_r      <= 1'b0;
      out_valid_r <= 1'b0;
    end else begin
      load_r      <= accept;
      out_valid_r <= (state == CORRECT);
      case (state)
        IDLE, DONE: begin
          if (accept) begin
            state <= RUN;
            cnt   <= `DIV_CNT_W'(`DIV_STEPS - 1);
          end
        end
        RUN: begin
          if (step) begin
            cnt <= cnt - 1'b1;
            if (cnt == '0)
              state <= CORRECT;
          end
        end
        CORRECT: state <= DONE;
        default: state <= IDLE;
      endcase
    end
  end

endmodule

// ==== verilog/div_operand_prep.sv ====
`timescale 1ns/1ps

`include "div_defs.svh"

module div_operand_prep
  import div_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      accept,
  input  div_req_t  req,
  output div_op_t   op,
  output div_sign_t sign,
  output div_word_t dividend_mag,
  output div_word_t divisor_mag
);

  logic      dividend_neg;
  logic      divisor_neg;
  div_word_t dividend_abs;
  div_word_t divisor_abs;

  assign dividend_neg = req.op.is_signed && req.dividend[`DIV_WIDTH-1];
  assign divisor_neg  = req.op.is_signed && req.divisor[`DIV_WIDTH-1];

  // The most negative value negates to itself, which read unsigned is 2**63
  assign dividend_abs = dividend_neg ? (~req.dividend + 1'b1) : req.dividend;
  assign divisor_abs  = divisor_neg ? (~req.divisor + 1'b1) : req.divisor;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      op   <= '0;
      sign <= '0;
    end else if (accept) begin
      op         <= req.op;
      sign.q_neg <= dividend_neg ^ divisor_neg;
      sign.r_neg <= dividend_neg;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      dividend_mag <= dividend_abs;
      divisor_mag  <= divisor_abs;
    end
  end

endmodule

// ==== verilog/div_pkg.sv ====
`include "div_defs.svh"

package div_pkg;

  typedef logic [`DIV_WIDTH-1:0] div_word_t;

  // Partial remainder carries a sign bit above the word
  typedef logic [`DIV_WIDTH:0] div_rem_t;

  // Field order matches div_type with is_signed in bit 0 and want_rem in bit 1
  typedef struct packed {
    logic want_rem;
    logic is_signed;
  } div_op_t;

  typedef struct packed {
    div_word_t dividend;
    div_word_t divisor;
    div_op_t   op;
  } div_req_t;

  typedef struct packed {
    logic q_neg;
    logic r_neg;
  } div_sign_t;

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    CORRECT,
    DONE
  } div_state_t;

endpackage

// ==== verilog/div_result_fix.sv ====
`timescale 1ns/1ps

module div_result_fix
  import div_pkg::*;
(
  input  div_op_t   op,
  input  div_sign_t sign,
  input  div_word_t quotient,
  input  div_word_t remainder,
  output div_word_t result
);

  div_word_t q_signed;
  div_word_t r_signed;

  // Quotient is negative when exactly one operand was
  assign q_signed = sign.q_neg ? (~quotient + 1'b1) : quotient;

  // Remainder follows the sign of the dividend
  assign r_signed = sign.r_neg ? (~remainder + 1'b1) : remainder;

  assign result = op.want_rem ? r_signed : q_signed;

endmodule

// ==== verilog/div_unit.sv ====
`timescale 1ns/1ps

module div_unit
  import div_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  div_word_t  dividend,
  input  div_word_t  divisor,
  input  logic [1:0] div_type,
  input  logic       div_valid,
  input  logic       flush,
  output logic       div_ready,
  output logic       out_valid,
  output div_word_t  result
);

  div_req_t  req;
  div_op_t   op;
  div_sign_t sign;
  div_word_t dividend_mag;
  div_word_t divisor_mag;
  div_word_t quotient;
  div_word_t remainder;
  logic      accept;
  logic      load;
  logic      step;
  logic      correct;

  assign req.dividend = dividend;
  assign req.divisor  = divisor;
  assign req.op       = div_op_t'(div_type);

  div_operand_prep div_operand_prep_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .accept       (accept),
    .req          (req),
    .op           (op),
    .sign         (sign),
    .dividend_mag (dividend_mag),
    .divisor_mag  (divisor_mag)
  );

  div_iter_ctrl div_iter_ctrl_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .div_valid (div_valid),
    .flush     (flush),
    .accept    (accept),
    .load      (load),
    .step      (step),
    .correct   (correct),
    .div_ready (div_ready),
    .out_valid (out_valid)
  );

  div_datapath div_datapath_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .load         (load),
    .step         (step),
    .correct      (correct),
    .dividend_mag (dividend_mag),
    .divisor_mag  (divisor_mag),
    .quotient     (quotient),
    .remainder    (remainder)
  );

  div_result_fix div_result_fix_i (
    .op        (op),
    .sign      (sign),
    .quotient  (quotient),
    .remainder (remainder),
    .result    (result)
  );

endmodule
